/* source/blob_extract_pkg.sv */
`default_nettype none

package blob_extract_pkg;

	// x or y of one pixel
	typedef logic [7:0] coord_t;

	// word address into the image memory
	typedef logic [15:0] pix_addr_t;

	// one image word holds background, zero (unlabelled) or a label
	typedef logic [7:0] pixel_t;

	typedef logic [7:0] label_t;

	// pixel count of one blob
	typedef logic [15:0] blob_size_t;

	// labels 0 and 1 are taken by foreground and background
	localparam label_t FIRST_LABEL = label_t'(2);

endpackage

`default_nettype wire

/* source/fill_stack.sv */
`default_nettype none

module fill_stack
	import blob_extract_pkg::*;
#(
	parameter int STACK_DEPTH = 32
) (
	input  wire logic modified_clock_two_div_by_two,
	input  wire logic arst_n,
	input  wire logic push,
	input  wire logic pop,
	input  coord_t    push_x,
	input  coord_t    push_y,
	output coord_t    top_x,
	output coord_t    top_y,
	output logic      stack_empty
);

	localparam int AW = $clog2(STACK_DEPTH);
	localparam int PW = $clog2(STACK_DEPTH + 1);

	coord_t          mem_x [STACK_DEPTH];
	coord_t          mem_y [STACK_DEPTH];
	logic [PW-1:0]   sp;     // number of entries
	logic [AW-1:0]   wr_idx;
	logic [AW-1:0]   rd_idx;

	assign wr_idx      = sp[AW-1:0];
	assign rd_idx      = wr_idx - 1'b1; // top entry
	assign stack_empty = (sp == '0);

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			sp <= '0;
		end else if (push) begin
			sp <= sp + 1'b1;
		end else if (pop) begin
			sp <= sp - 1'b1;
		end
	end

	// popped pair shows up one cycle later
	always_ff @(posedge modified_clock_two_div_by_two) begin
		if (push) begin
			mem_x[wr_idx] <= push_x;
			mem_y[wr_idx] <= push_y;
		end
		if (pop) begin
			top_x <= mem_x[rd_idx];
			top_y <= mem_y[rd_idx];
		end
	end

endmodule

`default_nettype wire

/* source/flood_fill_engine.sv */
`default_nettype none

module flood_fill_engine
	import blob_extract_pkg::*;
#(
	parameter int IMG_WIDTH  = 16,
	parameter int IMG_HEIGHT = 8,
	parameter int MARGIN     = 1
) (
	input  wire logic modified_clock_two_div_by_two,
	input  wire logic arst_n,
	input  wire logic start,
	input  pixel_t    mem_rdata,
	input  coord_t    top_x,
	input  coord_t    top_y,
	input  wire logic stack_empty,
	input  wire logic queue_has_room,
	output pix_addr_t mem_addr,
	output logic      mem_wren,
	output pixel_t    mem_wdata,
	output logic      push,
	output logic      pop,
	output coord_t    push_x,
	output coord_t    push_y,
	output logic      pix_valid,
	output logic      blob_open,
	output logic      blob_close,
	output coord_t    pix_x,
	output coord_t    pix_y,
	output logic      extraction_done
);

	// inner window inside the margin
	localparam coord_t XMIN = coord_t'(MARGIN);
	localparam coord_t XMAX = coord_t'(IMG_WIDTH - MARGIN - 1);
	localparam coord_t YMIN = coord_t'(MARGIN);
	localparam coord_t YMAX = coord_t'(IMG_HEIGHT - MARGIN - 1);

	typedef enum logic [4:0] {
		S_IDLE,
		S_SCAN_RD,
		S_SCAN_CHK,
		S_SCAN_NEXT,
		S_POP,
		S_POPD,
		S_UP_RD,
		S_UP_CHK,
		S_DN_RD,
		S_DN_CHK,
		S_WR,
		S_L_RD,
		S_L_CHK,
		S_R_RD,
		S_R_CHK,
		S_COL_END,
		S_CLOSE,
		S_DONE
	} fill_state_t;

	fill_state_t state;
	coord_t      sx, sy;         // raster scan position
	coord_t      cx, cy;         // fill cursor
	label_t      label;
	logic        span_left;
	logic        span_right;
	coord_t      rd_x, rd_y;
	logic        pix_zero;

	function automatic pix_addr_t pix_addr(input coord_t x, input coord_t y);
		return pix_addr_t'(y) * pix_addr_t'(IMG_WIDTH) + pix_addr_t'(x);
	endfunction

	assign pix_zero = (mem_rdata == pixel_t'(0));

	// address follows the state so the data comes back in the next cycle
	always_comb begin
		rd_x = cx;
		rd_y = cy;
		case (state)
			S_SCAN_RD: begin
				rd_x = sx;
				rd_y = sy;
			end
			S_UP_RD: rd_y = cy - 1'b1;
			S_L_RD:  rd_x = cx - 1'b1;
			S_R_RD:  rd_x = cx + 1'b1;
			default: ;
		endcase
	end

	assign mem_addr        = pix_addr(rd_x, rd_y);
	assign mem_wren        = (state == S_WR);
	assign mem_wdata       = label;
	assign pop             = (state == S_POP);
	assign pix_valid       = (state == S_WR);
	assign pix_x           = cx;
	assign pix_y           = cy;
	assign blob_open       = (state == S_SCAN_CHK) && pix_zero && queue_has_room;
	assign blob_close      = (state == S_CLOSE);
	assign extraction_done = (state == S_DONE);

	always_comb begin
		push   = 1'b0;
		push_x = cx;
		push_y = cy;
		case (state)
			S_SCAN_CHK: begin
				push   = pix_zero && queue_has_room; // seed
				push_x = sx;
				push_y = sy;
			end
			S_L_CHK: begin
				push   = pix_zero && !span_left;
				push_x = cx - 1'b1;
			end
			S_R_CHK: begin
				push   = pix_zero && !span_right;
				push_x = cx + 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_IDLE;
			sx         <= XMIN;
			sy         <= YMIN;
			cx         <= XMIN;
			cy         <= YMIN;
			label      <= FIRST_LABEL;
			span_left  <= 1'b0;
			span_right <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_DONE: begin
					if (start) begin
						sx    <= XMIN;
						sy    <= YMIN;
						label <= FIRST_LABEL;
						state <= S_SCAN_RD;
					end
				end
				S_SCAN_RD: state <= S_SCAN_CHK;
				S_SCAN_CHK: begin
					if (!pix_zero) begin
						state <= S_SCAN_NEXT;
					end else if (queue_has_room) begin
						state <= S_POP;
					end else begin
						state <= S_SCAN_RD; // hold until a record drains
					end
				end
				S_SCAN_NEXT: begin
					if (sx == XMAX) begin
						sx <= XMIN;
						if (sy == YMAX) begin
							state <= S_DONE;
						end else begin
							sy    <= sy + 1'b1;
							state <= S_SCAN_RD;
						end
					end else begin
						sx    <= sx + 1'b1;
						state <= S_SCAN_RD;
					end
				end
				S_POP: state <= S_POPD;
				S_POPD: begin
					cx         <= top_x;
					cy         <= top_y;
					span_left  <= 1'b0;
					span_right <= 1'b0;
					state      <= S_UP_RD;
				end
				S_UP_RD: state <= (cy == YMIN) ? S_DN_RD : S_UP_CHK;
				S_UP_CHK: begin
					if (pix_zero) begin
						cy    <= cy - 1'b1;
						state <= S_UP_RD;
					end else begin
						state <= S_DN_RD;
					end
				end
				S_DN_RD:  state <= S_DN_CHK;
				S_DN_CHK: state <= pix_zero ? S_WR : S_COL_END;
				S_WR:     state <= S_L_RD;
				S_L_RD: begin
					if (cx == XMIN) begin
						span_left <= 1'b0;
						state     <= S_R_RD;
					end else begin
						state <= S_L_CHK;
					end
				end
				S_L_CHK: begin
					span_left <= pix_zero;
					state     <= S_R_RD;
				end
				S_R_RD: begin
					if (cx == XMAX) begin
						span_right <= 1'b0;
						if (cy == YMAX) begin
							state <= S_COL_END;
						end else begin
							cy    <= cy + 1'b1;
							state <= S_DN_RD;
						end
					end else begin
						state <= S_R_CHK;
					end
				end
				S_R_CHK: begin
					span_right <= pix_zero;
					if (cy == YMAX) begin
						state <= S_COL_END;
					end else begin
						cy    <= cy + 1'b1;
						state <= S_DN_RD;
					end
				end
				S_COL_END: state <= stack_empty ? S_CLOSE : S_POP;
				S_CLOSE: begin
					label <= label + 1'b1;
					state <= S_SCAN_NEXT; // resume after the seed
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/blob_stats.sv */
`default_nettype none

module blob_stats
	import blob_extract_pkg::*;
(
	input  wire logic modified_clock_two_div_by_two,
	input  wire logic arst_n,
	input  wire logic start,
	input  wire logic pix_valid,
	input  wire logic blob_open,
	input  wire logic blob_close,
	input  coord_t    pix_x,
	input  coord_t    pix_y,
	output logic      rec_push,
	output label_t    rec_label,
	output blob_size_t rec_size,
	output coord_t    rec_min_x,
	output coord_t    rec_min_y,
	output coord_t    rec_max_x,
	output coord_t    rec_max_y
);

	label_t next_label; // tracks the engine's label counter

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			next_label <= FIRST_LABEL;
			rec_push   <= 1'b0;
		end else begin
			rec_push <= blob_close; // record is complete one cycle later
			if (start) begin
				next_label <= FIRST_LABEL;
			end else if (blob_open) begin
				next_label <= next_label + 1'b1;
			end
		end
	end

	// accumulators double as the record fields
	always_ff @(posedge modified_clock_two_div_by_two) begin
		if (blob_open) begin
			rec_label <= next_label;
			rec_size  <= '0;
		end else if (pix_valid) begin
			rec_size <= rec_size + 1'b1;
			if (rec_size == '0) begin
				rec_min_x <= pix_x; // first pixel sets the box
				rec_max_x <= pix_x;
				rec_min_y <= pix_y;
				rec_max_y <= pix_y;
			end else begin
				if (pix_x < rec_min_x)
					rec_min_x <= pix_x;
				if (pix_x > rec_max_x)
					rec_max_x <= pix_x;
				if (pix_y < rec_min_y)
					rec_min_y <= pix_y;
				if (pix_y > rec_max_y)
					rec_max_y <= pix_y;
			end
		end
	end

endmodule

`default_nettype wire

/* source/record_queue.sv */
`default_nettype none

module record_queue
	import blob_extract_pkg::*;
#(
	parameter int RECORD_DEPTH = 4
) (
	input  wire logic  modified_clock_two_div_by_two,
	input  wire logic  arst_n,
	input  wire logic  rec_push,
	input  label_t     rec_label,
	input  blob_size_t rec_size,
	input  coord_t     rec_min_x,
	input  coord_t     rec_min_y,
	input  coord_t     rec_max_x,
	input  coord_t     rec_max_y,
	input  wire logic  blob_ready,
	output logic       queue_has_room,
	output logic       blob_valid,
	output label_t     blob_label,
	output blob_size_t blob_size,
	output coord_t     blob_min_x,
	output coord_t     blob_min_y,
	output coord_t     blob_max_x,
	output coord_t     blob_max_y
);

	localparam int AW = (RECORD_DEPTH > 1) ? $clog2(RECORD_DEPTH) : 1;
	localparam int CW = $clog2(RECORD_DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(RECORD_DEPTH - 1);

	label_t        q_label [RECORD_DEPTH];
	blob_size_t    q_size  [RECORD_DEPTH];
	coord_t        q_min_x [RECORD_DEPTH];
	coord_t        q_min_y [RECORD_DEPTH];
	coord_t        q_max_x [RECORD_DEPTH];
	coord_t        q_max_y [RECORD_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          wr_en;
	logic          rd_en;

	assign queue_has_room = (count < CW'(RECORD_DEPTH));
	assign blob_valid     = (count != '0);
	assign wr_en          = rec_push && queue_has_room;
	assign rd_en          = blob_valid && blob_ready;

	// head entry stays put until it is taken
	assign blob_label = q_label[rd_ptr];
	assign blob_size  = q_size[rd_ptr];
	assign blob_min_x = q_min_x[rd_ptr];
	assign blob_min_y = q_min_y[rd_ptr];
	assign blob_max_x = q_max_x[rd_ptr];
	assign blob_max_y = q_max_y[rd_ptr];

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge modified_clock_two_div_by_two) begin
		if (wr_en) begin
			q_label[wr_ptr] <= rec_label;
			q_size[wr_ptr]  <= rec_size;
			q_min_x[wr_ptr] <= rec_min_x;
			q_min_y[wr_ptr] <= rec_min_y;
			q_max_x[wr_ptr] <= rec_max_x;
			q_max_y[wr_ptr] <= rec_max_y;
		end
	end

endmodule

`default_nettype wire

/* source/blob_extract_top.sv */
`default_nettype none

module blob_extract_top
	import blob_extract_pkg::*;
#(
	parameter int IMG_WIDTH    = 16,
	parameter int IMG_HEIGHT   = 8,
	parameter int MARGIN       = 1,
	parameter int STACK_DEPTH  = 32,
	parameter int RECORD_DEPTH = 4
) (
	input  wire logic       modified_clock_two_div_by_two,
	input  wire logic       arst_n,
	input  wire logic       start,
	output logic            extraction_done,
	output pix_addr_t       mem_addr,
	output logic            mem_wren,
	output pixel_t          mem_wdata,
	input  pixel_t          mem_rdata,
	output logic            blob_valid,
	input  wire logic       blob_ready,
	output label_t          blob_label,
	output blob_size_t      blob_size,
	output coord_t          blob_min_x,
	output coord_t          blob_min_y,
	output coord_t          blob_max_x,
	output coord_t          blob_max_y
);

	// engine <-> stack
	logic   push;
	logic   pop;
	coord_t push_x;
	coord_t push_y;
	coord_t top_x;
	coord_t top_y;
	logic   stack_empty;

	// engine -> stats
	logic   pix_valid;
	logic   blob_open;
	logic   blob_close;
	coord_t pix_x;
	coord_t pix_y;

	// stats -> queue
	logic       rec_push;
	label_t     rec_label;
	blob_size_t rec_size;
	coord_t     rec_min_x;
	coord_t     rec_min_y;
	coord_t     rec_max_x;
	coord_t     rec_max_y;
	logic       queue_has_room;

	flood_fill_engine #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.MARGIN     (MARGIN)
	) u_engine (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n          (arst_n),
		.start           (start),
		.mem_rdata       (mem_rdata),
		.top_x           (top_x),
		.top_y           (top_y),
		.stack_empty     (stack_empty),
		.queue_has_room  (queue_has_room),
		.mem_addr        (mem_addr),
		.mem_wren        (mem_wren),
		.mem_wdata       (mem_wdata),
		.push            (push),
		.pop             (pop),
		.push_x          (push_x),
		.push_y          (push_y),
		.pix_valid       (pix_valid),
		.blob_open       (blob_open),
		.blob_close      (blob_close),
		.pix_x           (pix_x),
		.pix_y           (pix_y),
		.extraction_done (extraction_done)
	);

	fill_stack #(
		.STACK_DEPTH (STACK_DEPTH)
	) u_stack (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n      (arst_n),
		.push        (push),
		.pop         (pop),
		.push_x      (push_x),
		.push_y      (push_y),
		.top_x       (top_x),
		.top_y       (top_y),
		.stack_empty (stack_empty)
	);

	blob_stats u_stats (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n     (arst_n),
		.start      (start),
		.pix_valid  (pix_valid),
		.blob_open  (blob_open),
		.blob_close (blob_close),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.rec_push   (rec_push),
		.rec_label  (rec_label),
		.rec_size   (rec_size),
		.rec_min_x  (rec_min_x),
		.rec_min_y  (rec_min_y),
		.rec_max_x  (rec_max_x),
		.rec_max_y  (rec_max_y)
	);

	record_queue #(
		.RECORD_DEPTH (RECORD_DEPTH)
	) u_queue (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n         (arst_n),
		.rec_push       (rec_push),
		.rec_label      (rec_label),
		.rec_size       (rec_size),
		.rec_min_x      (rec_min_x),
		.rec_min_y      (rec_min_y),
		.rec_max_x      (rec_max_x),
		.rec_max_y      (rec_max_y),
		.blob_ready     (blob_ready),
		.queue_has_room (queue_has_room),
		.blob_valid     (blob_valid),
		.blob_label     (blob_label),
		.blob_size      (blob_size),
		.blob_min_x     (blob_min_x),
		.blob_min_y     (blob_min_y),
		.blob_max_x     (blob_max_x),
		.blob_max_y     (blob_max_y)
	);

endmodule

`default_nettype wire

/* verif/image_mem_model.sv */
`default_nettype none

module image_mem_model
	import blob_extract_pkg::*;
#(
	parameter int DEPTH = 128
) (
	input  wire logic modified_clock_two_div_by_two,
	input  pix_addr_t mem_addr,
	input  wire logic mem_wren,
	input  pixel_t    mem_wdata,
	output pixel_t    mem_rdata
);

	// image words loaded and read back by the testbench between runs
	pixel_t mem [DEPTH];

	// single port so a write cycle returns no read data
	always @(posedge modified_clock_two_div_by_two) begin
		if (mem_wren) begin
			mem[mem_addr] <= mem_wdata;
		end else begin
			mem_rdata <= mem[mem_addr]; // valid one cycle after the address
		end
	end

endmodule

`default_nettype wire

/* verif/blob_extract_asserts.sv */
`default_nettype none

module blob_extract_asserts
	import blob_extract_pkg::*;
(
	input wire logic modified_clock_two_div_by_two,
	input wire logic arst_n,
	input wire logic mem_wren,
	input wire logic extraction_done,
	input wire logic blob_valid,
	input wire logic blob_ready,
	input label_t    blob_label,
	input blob_size_t blob_size,
	input coord_t    blob_min_x,
	input coord_t    blob_min_y,
	input coord_t    blob_max_x,
	input coord_t    blob_max_y
);

	int failures = 0; // polled by the testbench

	// queue comes out of reset empty
	valid_low_after_reset: assert property (
		@(posedge modified_clock_two_div_by_two) $rose(arst_n) |-> !blob_valid
	) else begin
		failures++;
		$error("blob_valid high right after reset");
	end

	// a record waiting for ready must not change
	record_held: assert property (
		@(posedge modified_clock_two_div_by_two) disable iff (!arst_n)
		blob_valid && !blob_ready |=> blob_valid && $stable(blob_label)
			&& $stable(blob_size) && $stable(blob_min_x) && $stable(blob_min_y)
			&& $stable(blob_max_x) && $stable(blob_max_y)
	) else begin
		failures++;
		$error("blob record dropped or changed before blob_ready");
	end

	no_write_when_done: assert property (
		@(posedge modified_clock_two_div_by_two) disable iff (!arst_n)
		mem_wren |-> !extraction_done
	) else begin
		failures++;
		$error("mem_wren high while extraction_done is high");
	end

endmodule

`default_nettype wire

/* verif/blob_extract_tb.sv */
`default_nettype none

module blob_extract_tb
	import blob_extract_pkg::*;
();

	localparam int IMG_WIDTH   = 16;
	localparam int IMG_HEIGHT  = 8;
	localparam int NUM_PIX     = IMG_WIDTH * IMG_HEIGHT;
	localparam int CASE_LIMIT  = 16 * IMG_WIDTH * IMG_HEIGHT; // cycles allowed per case
	localparam int CASE_WORDS  = 1024;
	localparam int MAX_RECORDS = 16;

	logic       modified_clock_two_div_by_two = 1'b0;
	logic       arst_n     = 1'b0;
	logic       start      = 1'b0;
	logic       blob_ready = 1'b0;
	logic       extraction_done;
	pix_addr_t  mem_addr;
	logic       mem_wren;
	pixel_t     mem_wdata;
	pixel_t     mem_rdata;
	logic       blob_valid;
	label_t     blob_label;
	blob_size_t blob_size;
	coord_t     blob_min_x;
	coord_t     blob_min_y;
	coord_t     blob_max_x;
	coord_t     blob_max_y;

	logic [15:0] case_words [CASE_WORDS];
	pixel_t      exp_image [NUM_PIX];
	label_t      exp_label [MAX_RECORDS];
	blob_size_t  exp_size  [MAX_RECORDS];
	coord_t      exp_min_x [MAX_RECORDS];
	coord_t      exp_min_y [MAX_RECORDS];
	coord_t      exp_max_x [MAX_RECORDS];
	coord_t      exp_max_y [MAX_RECORDS];
	int          exp_count   = 0;
	int          got_count   = 0;
	int          cycle_count = 0;
	int          case_base   = 0;
	logic [31:0] rand_state  = 32'd25;

	always #5 modified_clock_two_div_by_two = ~modified_clock_two_div_by_two;

	blob_extract_top #(
		.IMG_WIDTH    (IMG_WIDTH),
		.IMG_HEIGHT   (IMG_HEIGHT),
		.MARGIN       (1),
		.STACK_DEPTH  (32),
		.RECORD_DEPTH (4)
	) dut (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n          (arst_n),
		.start           (start),
		.extraction_done (extraction_done),
		.mem_addr        (mem_addr),
		.mem_wren        (mem_wren),
		.mem_wdata       (mem_wdata),
		.mem_rdata       (mem_rdata),
		.blob_valid      (blob_valid),
		.blob_ready      (blob_ready),
		.blob_label      (blob_label),
		.blob_size       (blob_size),
		.blob_min_x      (blob_min_x),
		.blob_min_y      (blob_min_y),
		.blob_max_x      (blob_max_x),
		.blob_max_y      (blob_max_y)
	);

	image_mem_model #(
		.DEPTH (NUM_PIX)
	) u_mem (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.mem_addr  (mem_addr),
		.mem_wren  (mem_wren),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	bind blob_extract_top blob_extract_asserts u_asserts (
		.modified_clock_two_div_by_two (modified_clock_two_div_by_two),
		.arst_n          (arst_n),
		.mem_wren        (mem_wren),
		.extraction_done (extraction_done),
		.blob_valid      (blob_valid),
		.blob_ready      (blob_ready),
		.blob_label      (blob_label),
		.blob_size       (blob_size),
		.blob_min_x      (blob_min_x),
		.blob_min_y      (blob_min_y),
		.blob_max_x      (blob_max_x),
		.blob_max_y      (blob_max_y)
	);

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic pixel_check(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic label_check(input string name, input label_t got, input label_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic size_check(input string name, input blob_size_t got,
			input blob_size_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic coord_check(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// input image goes straight into the memory model
	task automatic load_case(input int first, output int next);
		int pos;
		int i;
		int r;
		pos = first;
		exp_count = int'(case_words[pos]);
		pos++;
		if (exp_count > MAX_RECORDS) begin
			$display("case file asks for %0d records, the table holds %0d",
				exp_count, MAX_RECORDS);
			abort_run();
		end
		for (i = 0; i < NUM_PIX; i++) begin
			u_mem.mem[i] = pixel_t'(case_words[pos + i]);
			exp_image[i] = pixel_t'(case_words[pos + NUM_PIX + i]);
		end
		pos += 2 * NUM_PIX;
		for (r = 0; r < exp_count; r++) begin
			exp_label[r] = label_t'(case_words[pos]);
			exp_size[r]  = blob_size_t'(case_words[pos + 1]);
			exp_min_x[r] = coord_t'(case_words[pos + 2]);
			exp_min_y[r] = coord_t'(case_words[pos + 3]);
			exp_max_x[r] = coord_t'(case_words[pos + 4]);
			exp_max_y[r] = coord_t'(case_words[pos + 5]);
			pos += 6;
			// labels count up from FIRST_LABEL in seed order
			if (exp_label[r] != label_t'(FIRST_LABEL + r)) begin
				$display("case file record %0d has label %0d out of sequence",
					r, exp_label[r]);
				abort_run();
			end
		end
		next = pos;
	endtask

	task automatic run_case(input int index);
		int i;
		@(posedge modified_clock_two_div_by_two);
		#1;
		case_base = cycle_count;
		got_count = 0;
		start = 1'b1;
		@(posedge modified_clock_two_div_by_two);
		#1;
		start = 1'b0;
		while (!extraction_done)
			@(negedge modified_clock_two_div_by_two);
		while (got_count < exp_count)
			@(negedge modified_clock_two_div_by_two);
		@(negedge modified_clock_two_div_by_two); // last transfer has happened
		if (blob_valid) begin
			$display("case %0d: a record is left after the %0d expected ones",
				index, exp_count);
			abort_run();
		end
		if (!extraction_done) begin
			$display("case %0d: extraction_done fell before the next start", index);
			abort_run();
		end
		for (i = 0; i < NUM_PIX; i++)
			pixel_check($sformatf("mem[%0d]", i), u_mem.mem[i], exp_image[i]);
		$display("case %0d: %0d records, image matches", index, exp_count);
	endtask

	// ready pattern changes just after each rising edge
	always @(posedge modified_clock_two_div_by_two) begin
		#1;
		rand_state = next_random(rand_state);
		blob_ready = rand_state[16];
	end

	// a transfer seen here completes on the next rising edge
	always @(negedge modified_clock_two_div_by_two) begin
		if (arst_n && blob_valid && blob_ready) begin
			if (got_count >= exp_count) begin
				$display("record with label %0d arrived beyond the %0d expected",
					blob_label, exp_count);
				abort_run();
			end else begin
				label_check("blob_label", blob_label, exp_label[got_count]);
				size_check("blob_size", blob_size, exp_size[got_count]);
				coord_check("blob_min_x", blob_min_x, exp_min_x[got_count]);
				coord_check("blob_min_y", blob_min_y, exp_min_y[got_count]);
				coord_check("blob_max_x", blob_max_x, exp_max_x[got_count]);
				coord_check("blob_max_y", blob_max_y, exp_max_y[got_count]);
				got_count = got_count + 1;
			end
		end
	end

	// watchdog and poll of the bound assertions
	always @(negedge modified_clock_two_div_by_two) begin
		cycle_count = cycle_count + 1;
		if (cycle_count - case_base > CASE_LIMIT) begin
			$display("run hung: case not finished within %0d cycles", CASE_LIMIT);
			abort_run();
		end else if (dut.u_asserts.failures != 0) begin
			$display("a bound assertion on the DUT ports failed");
			abort_run();
		end
	end

	initial begin
		int pos;
		int n_cases;
		int c;
		$readmemh("verif/blob_cases.txt", case_words);
		if ($isunknown(case_words[0]) || case_words[0] == '0) begin
			$display("case file verif/blob_cases.txt is missing or holds no case");
			abort_run();
		end
		n_cases = int'(case_words[0]);
		repeat (3) @(posedge modified_clock_two_div_by_two);
		#1;
		arst_n = 1'b1;
		pos = 1;
		for (c = 0; c < n_cases; c++) begin
			load_case(pos, pos);
			run_case(c + 1);
		end
		if (dut.u_asserts.failures != 0) begin
			$display("%0d bound assertion failures", dut.u_asserts.failures);
			abort_run();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verif/blob_cases.txt */
// word 0: number of cases; each case: record count, 8 input rows, 8 expected rows
// then one record per line: label size min_x min_y max_x max_y (all hex)
3
// case 1: seven blobs, zeros on the border stay
7
01 01 01 01 01 01 01 01 00 01 01 01 01 01 01 01
01 00 00 01 01 01 01 01 00 01 01 01 01 00 00 01
01 00 01 01 00 01 00 01 00 01 01 01 01 01 00 01
01 00 00 01 00 01 00 01 00 00 00 01 01 01 00 00
01 01 01 01 00 00 00 01 01 01 01 01 00 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 00 01 01 01 01 01 01 01 01 01 00 00 00 00 01
01 01 01 01 01 01 01 01 01 01 01 01 00 01 01 01
01 01 01 01 01 01 01 01 00 01 01 01 01 01 01 01
01 02 02 01 01 01 01 01 03 01 01 01 01 04 04 01
01 02 01 01 05 01 05 01 03 01 01 01 01 01 04 01
01 02 02 01 05 01 05 01 03 03 03 01 01 01 04 00
01 01 01 01 05 05 05 01 01 01 01 01 06 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 07 01 01 01 01 01 01 01 01 01 08 08 08 08 01
01 01 01 01 01 01 01 01 01 01 01 01 00 01 01 01
02 0005 01 01 02 03
03 0005 08 01 0a 03
04 0004 0d 01 0e 03
05 0007 04 02 06 04
06 0001 0c 04 0c 04
07 0001 01 06 01 06
08 0004 0b 06 0e 06
// case 2: no foreground inside the margin, old labels untouched
0
00 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 09 01 01 01 01 01 01 01 01 01 00
01 01 01 01 01 01 01 01 01 01 03 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 00 01 01 01 01 01 01 01 01
00 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 09 01 01 01 01 01 01 01 01 01 00
01 01 01 01 01 01 01 01 01 01 03 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 00 01 01 01 01 01 01 01 01
// case 3: ring along the margin with small blobs inside, labels restart
5
01 01 01 01 01 00 01 01 01 01 01 01 01 01 01 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 01 01 01 01 01 01 01 01 01 01 01 01 00 01
01 00 01 00 00 01 01 00 01 01 01 01 01 01 00 01
01 00 01 00 01 01 01 00 01 01 00 00 01 01 00 01
01 00 01 01 01 01 01 01 01 01 01 00 01 01 01 01
01 00 00 00 00 00 01 01 01 01 01 00 01 01 00 00
01 01 01 01 01 01 01 01 01 01 01 00 01 01 01 01
01 01 01 01 01 00 01 01 01 01 01 01 01 01 01 01
01 02 02 02 02 02 02 02 02 02 02 02 02 02 02 01
01 02 01 01 01 01 01 01 01 01 01 01 01 01 02 01
01 02 01 03 03 01 01 04 01 01 01 01 01 01 02 01
01 02 01 03 01 01 01 04 01 01 05 05 01 01 02 01
01 02 01 01 01 01 01 01 01 01 01 05 01 01 01 01
01 02 02 02 02 02 01 01 01 01 01 05 01 01 06 00
01 01 01 01 01 01 01 01 01 01 01 00 01 01 01 01
02 001a 01 01 0e 06
03 0003 03 03 04 04
04 0002 07 03 07 04
05 0004 0a 04 0b 06
06 0001 0e 06 0e 06

/* tb.f */
source/blob_extract_pkg.sv
source/fill_stack.sv
source/flood_fill_engine.sv
source/blob_stats.sv
source/record_queue.sv
source/blob_extract_top.sv
verif/image_mem_model.sv
verif/blob_extract_asserts.sv
verif/blob_extract_tb.sv
